//--- filelist.f
rtl/cache_pkg.sv
rtl/dram_app_pkg.sv
rtl/cfg_regs.sv
rtl/test_master.sv
rtl/block_cache.sv
rtl/cache_to_app.sv
rtl/cache_mesh_top.sv
verif/dram_app_model.sv
verif/cache_mesh_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module cache_mesh_tb \
		-f filelist.f --Mdir obj_dir
	./obj_dir/Vcache_mesh_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q '\*\*\* FAILED \*\*\*' sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/cache_mesh_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_mesh_tb
  import cache_pkg::*;
  import dram_app_pkg::*;
();

  // the runs move 16, 128, 128 and 64 words summed over both masters.
  localparam int timeout_cycles_lp = (16 + 128 + 128 + 64) * 2 * 40 + 1000;

  logic clk;
  logic reset;
  logic cfg_we;
  logic [cfg_addr_width_lp-1:0] cfg_addr;
  logic [word_width_lp-1:0] cfg_wdata;
  logic [word_width_lp-1:0] cfg_rdata;
  logic finish;
  logic app_en;
  logic app_rdy;
  app_cmd_e app_cmd;
  logic [app_addr_width_lp-1:0] app_addr;
  logic app_wdf_wren;
  logic app_wdf_rdy;
  logic [app_data_width_lp-1:0] app_wdf_data;
  logic app_rd_data_valid;
  logic [app_data_width_lp-1:0] app_rd_data;
  logic init_calib;

  logic stall_mode;
  logic [15:0] lfsr;
  int cycles;
  int checks;
  int errors;

  // every configured window with the latest last.
  logic [31:0] win_base [16];
  logic [31:0] win_count [16];
  logic [31:0] win_key [16];
  int num_windows;

  cache_mesh_top dut (
    .clk_i(clk)
    ,.reset_i(reset)
    ,.cfg_we_i(cfg_we)
    ,.cfg_addr_i(cfg_addr)
    ,.cfg_wdata_i(cfg_wdata)
    ,.cfg_rdata_o(cfg_rdata)
    ,.finish_o(finish)
    ,.app_en_o(app_en)
    ,.app_rdy_i(app_rdy)
    ,.app_cmd_o(app_cmd)
    ,.app_addr_o(app_addr)
    ,.app_wdf_wren_o(app_wdf_wren)
    ,.app_wdf_rdy_i(app_wdf_rdy)
    ,.app_wdf_data_o(app_wdf_data)
    ,.app_rd_data_valid_i(app_rd_data_valid)
    ,.app_rd_data_i(app_rd_data)
    ,.init_calib_complete_i(init_calib)
  );

  dram_app_model mem_model (
    .clk_i(clk)
    ,.reset_i(reset)
    ,.app_en_i(app_en)
    ,.app_rdy_i(app_rdy)
    ,.app_cmd_i(app_cmd)
    ,.app_addr_i(app_addr)
    ,.app_wdf_wren_i(app_wdf_wren)
    ,.app_wdf_rdy_i(app_wdf_rdy)
    ,.app_wdf_data_i(app_wdf_data)
    ,.app_rd_data_valid_o(app_rd_data_valid)
    ,.app_rd_data_o(app_rd_data)
  );

  always #5 clk = ~clk;

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  always @(posedge clk) begin
    #1;
    if (stall_mode) begin
      lfsr = lfsr_next(lfsr);
      app_rdy = lfsr[0];
      lfsr = lfsr_next(lfsr);
      app_wdf_rdy = lfsr[0];
    end else begin
      app_rdy = 1'b1;
      app_wdf_rdy = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= timeout_cycles_lp) begin
      $display("timeout, the run has not finished after %0d cycles", cycles);
      $display("checks %0d, errors %0d", checks, errors);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string what, input logic [word_width_lp-1:0] actual,
                            input logic [word_width_lp-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t: %s, expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic check_block(input string what, input logic [app_data_width_lp-1:0] actual,
                             input logic [app_data_width_lp-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t: %s, expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  task automatic check_cmd(input string what, input app_cmd_e actual, input app_cmd_e expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t: %s, expected %s, got %s", $time, what, expected.name(), actual.name());
    end
  endtask

  task automatic cfg_write(input int addr, input logic [31:0] data);
    tick();
    cfg_we = 1'b1;
    cfg_addr = cfg_addr_width_lp'(addr);
    cfg_wdata = data;
    tick();
    cfg_we = 1'b0;
  endtask

  task automatic cfg_read(input int addr, output logic [31:0] data);
    tick();
    cfg_we = 1'b0;
    cfg_addr = cfg_addr_width_lp'(addr);
    @(negedge clk);
    data = cfg_rdata;
  endtask

  task automatic configure_master(input int m, input logic [31:0] base,
                                  input logic [31:0] count, input logic [31:0] key);
    cfg_write(3*m, base);
    cfg_write(3*m+1, count);
    cfg_write(3*m+2, key);
    win_base[num_windows] = base;
    win_count[num_windows] = count;
    win_key[num_windows] = key;
    num_windows++;
  endtask

  // start the masters in mask and wait for their done flags to drop and rise.
  task automatic run_masters(input logic [1:0] mask);
    logic [31:0] status;
    cfg_write(cfg_start_addr_lp, {30'b0, mask});
    do begin
      cfg_read(cfg_status_addr_lp, status);
    end while ((status[1:0] & mask) != 2'b00);
    do begin
      cfg_read(cfg_status_addr_lp, status);
    end while ((status[1:0] & mask) != mask);
  endtask

  // word k of a window holds key ^ address and the latest window wins.
  function automatic logic [31:0] expected_word(input logic [31:0] addr, output logic found);
    logic [31:0] word;
    found = 1'b0;
    word = '0;
    for (int w = 0; w < num_windows; w++) begin
      if ((addr >= win_base[w]) && (addr < win_base[w] + 4 * win_count[w])) begin
        found = 1'b1;
        word = win_key[w] ^ addr;
      end
    end
    return word;
  endfunction

  task automatic clear_log();
    mem_model.log_addr.delete();
    mem_model.log_data.delete();
    mem_model.log_cmd.delete();
  endtask

  task automatic check_write_log(input int expected_count);
    logic [31:0] addr;
    logic [127:0] block;
    logic found;
    check_word("write-back count", 32'(mem_model.log_addr.size()), 32'(expected_count));
    for (int i = 0; i < mem_model.log_addr.size(); i++) begin
      for (int w = 0; w < block_words_lp; w++) begin
        addr = (32'(mem_model.log_addr[i]) << 4) + 32'(4 * w);
        block[32*w +: 32] = expected_word(addr, found);
        if (!found) begin
          errors++;
          $display("FAIL %0t: write-back to %h lies outside every configured window",
                   $time, addr);
        end
      end
      check_block("write-back data", mem_model.log_data[i], block);
    end
  endtask

  task automatic check_commands(input logic reads_only, input int expected_writes);
    app_cmd_e cmd;
    int writes;
    writes = 0;
    for (int i = 0; i < mem_model.log_cmd.size(); i++) begin
      cmd = mem_model.log_cmd[i];
      if (!reads_only && (cmd === APP_CMD_WRITE)) begin
        writes++;
      end else begin
        check_cmd("command", cmd, APP_CMD_READ);
      end
    end
    if (!reads_only) begin
      check_word("write command count", 32'(writes), 32'(expected_writes));
    end
  endtask

  task automatic test_reset();
    logic [31:0] status;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_word("app_en in reset", 32'(app_en), 32'h0);
        check_word("app_wdf_wren in reset", 32'(app_wdf_wren), 32'h0);
        check_word("finish in reset", 32'(finish), 32'h0);
      end
    end
    tick();
    reset = 1'b0;
    init_calib = 1'b1;
    @(negedge clk);
    check_word("app_en after reset", 32'(app_en), 32'h0);
    check_word("app_wdf_wren after reset", 32'(app_wdf_wren), 32'h0);
    check_word("finish after reset", 32'(finish), 32'h0);
    cfg_read(cfg_status_addr_lp, status);
    check_word("status after reset", status, 32'h0);
  endtask

  task automatic test_readback();
    logic [31:0] value;
    logic [31:0] data;
    for (int m = 0; m < num_masters_lp; m++) begin
      for (int r = 0; r < 3; r++) begin
        value = {8'ha0 + 8'(m), 8'h10 * 8'(r + 1), 16'h05c3 + 16'(3 * m + r)};
        // count is 16 bits wide.
        if (r == 1) begin
          value[31:16] = '0;
        end
        cfg_write(3*m + r, value);
        cfg_read(3*m + r, data);
        check_word("register readback", data, value);
      end
    end
    cfg_read(cfg_status_addr_lp, data);
    check_word("status after register writes", data, 32'h0);
  endtask

  task automatic test_fits_in_cache();
    logic [31:0] status;
    clear_log();
    configure_master(0, 32'h0000_0100, 32'd8, 32'h3c3c_1234);
    run_masters(2'b01);
    cfg_read(cfg_status_addr_lp, status);
    check_word("status after master 0", status, 32'h0000_0001);
    configure_master(1, 32'h0000_1000, 32'd8, 32'h7e57_0001);
    run_masters(2'b10);
    cfg_read(cfg_status_addr_lp, status);
    check_word("status after master 1", status, 32'h0000_0003);
    check_word("finish", 32'(finish), 32'h1);
    check_commands(1'b1, 0);
    check_write_log(0);
  endtask

  // 64 words are 16 blocks over 8 sets, so each pass evicts a full cache.
  task automatic test_overflow(input logic [31:0] key0, input logic [31:0] key1,
                               input logic stall, input int expected_writes);
    logic [31:0] status;
    stall_mode = stall;
    clear_log();
    configure_master(0, 32'h0000_2000, 32'd64, key0);
    configure_master(1, 32'h0000_3000, 32'd64, key1);
    run_masters(2'b11);
    cfg_read(cfg_status_addr_lp, status);
    check_word("status after overflow run", status, 32'h0000_0003);
    check_word("finish", 32'(finish), 32'h1);
    check_commands(1'b0, expected_writes);
    check_write_log(expected_writes);
    stall_mode = 1'b0;
  endtask

  task automatic test_restart();
    logic [31:0] status;
    clear_log();
    configure_master(0, 32'h0000_2000, 32'd64, 32'h6d2b_79f5);
    run_masters(2'b01);
    cfg_read(cfg_status_addr_lp, status);
    check_word("status after restart", status, 32'h0000_0003);
    check_word("finish", 32'(finish), 32'h1);
    check_commands(1'b0, 16);
    check_write_log(16);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    cfg_we = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    app_rdy = 1'b1;
    app_wdf_rdy = 1'b1;
    init_calib = 1'b0;
    stall_mode = 1'b0;
    lfsr = 16'd44;
    cycles = 0;
    checks = 0;
    errors = 0;
    num_windows = 0;

    test_reset();
    test_readback();
    test_fits_in_cache();
    // per cache 2 dirty blocks from the small run plus 8 per pass are written back.
    test_overflow(32'h1357_9bdf, 32'h2468_ace0, 1'b0, 36);
    // caches start clean, so only the 16 dirty victims per cache remain.
    test_overflow(32'h5a5a_0f0f, 32'h0f1e_2d3c, 1'b1, 32);
    test_restart();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/dram_app_model.sv
`timescale 1ns/1ps
`default_nettype none

module dram_app_model
  import dram_app_pkg::*;
(
  input logic clk_i
  ,input logic reset_i

  ,input logic app_en_i
  ,input logic app_rdy_i
  ,input app_cmd_e app_cmd_i
  ,input logic [app_addr_width_lp-1:0] app_addr_i
  ,input logic app_wdf_wren_i
  ,input logic app_wdf_rdy_i
  ,input logic [app_data_width_lp-1:0] app_wdf_data_i
  ,output logic app_rd_data_valid_o
  ,output logic [app_data_width_lp-1:0] app_rd_data_o
);

  localparam int rd_latency_lp = 3;

  logic [app_data_width_lp-1:0] mem [logic [app_addr_width_lp-1:0]];

  // commands and write data may be accepted in either order.
  logic [app_addr_width_lp-1:0] wr_addr_q [$];
  logic [app_data_width_lp-1:0] wr_data_q [$];
  logic [app_addr_width_lp-1:0] rd_addr_q [$];
  int rd_due_q [$];

  // logs read back by the testbench.
  logic [app_addr_width_lp-1:0] log_addr [$];
  logic [app_data_width_lp-1:0] log_data [$];
  app_cmd_e log_cmd [$];

  logic rd_valid_r = 1'b0;
  logic [app_data_width_lp-1:0] rd_data_r = '0;
  logic [app_addr_width_lp-1:0] addr;
  logic [app_data_width_lp-1:0] data;
  int cycle_count = 0;

  assign app_rd_data_valid_o = rd_valid_r;
  assign app_rd_data_o = rd_data_r;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (reset_i) begin
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
      rd_due_q.delete();
    end else begin
      if (app_en_i && app_rdy_i) begin
        log_cmd.push_back(app_cmd_i);
        if (app_cmd_i == APP_CMD_WRITE) begin
          wr_addr_q.push_back(app_addr_i);
        end else begin
          rd_addr_q.push_back(app_addr_i);
          rd_due_q.push_back(cycle_count + rd_latency_lp);
        end
      end
      if (app_wdf_wren_i && app_wdf_rdy_i) begin
        wr_data_q.push_back(app_wdf_data_i);
      end
      while ((wr_addr_q.size() > 0) && (wr_data_q.size() > 0)) begin
        addr = wr_addr_q.pop_front();
        data = wr_data_q.pop_front();
        mem[addr] = data;
        log_addr.push_back(addr);
        log_data.push_back(data);
      end
    end
    #1;
    rd_valid_r = 1'b0;
    if (!reset_i && (rd_due_q.size() > 0) && (rd_due_q[0] <= cycle_count)) begin
      addr = rd_addr_q.pop_front();
      void'(rd_due_q.pop_front());
      // unwritten blocks read as zero.
      rd_data_r = mem.exists(addr) ? mem[addr] : '0;
      rd_valid_r = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cache_mesh_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_mesh_top
  import cache_pkg::*;
  import dram_app_pkg::*;
(
  input logic clk_i
  ,input logic reset_i

  ,input logic cfg_we_i
  ,input logic [cfg_addr_width_lp-1:0] cfg_addr_i
  ,input logic [word_width_lp-1:0] cfg_wdata_i
  ,output logic [word_width_lp-1:0] cfg_rdata_o

  ,output logic finish_o

  ,output logic app_en_o
  ,input logic app_rdy_i
  ,output app_cmd_e app_cmd_o
  ,output logic [app_addr_width_lp-1:0] app_addr_o
  ,output logic app_wdf_wren_o
  ,input logic app_wdf_rdy_i
  ,output logic [app_data_width_lp-1:0] app_wdf_data_o
  ,input logic app_rd_data_valid_i
  ,input logic [app_data_width_lp-1:0] app_rd_data_i
  ,input logic init_calib_complete_i
);

  logic [num_masters_lp-1:0][addr_width_lp-1:0] base;
  logic [num_masters_lp-1:0][count_width_lp-1:0] count;
  logic [num_masters_lp-1:0][word_width_lp-1:0] key;
  logic [num_masters_lp-1:0] start;
  logic [num_masters_lp-1:0] done;
  logic [num_masters_lp-1:0][count_width_lp-1:0] mismatch;

  logic [num_masters_lp-1:0] req_v;
  logic [num_masters_lp-1:0] req_ready;
  cache_op_e req_op [num_masters_lp];
  logic [num_masters_lp-1:0][addr_width_lp-1:0] req_addr;
  logic [num_masters_lp-1:0][word_width_lp-1:0] req_wdata;
  logic [num_masters_lp-1:0] resp_v;
  logic [num_masters_lp-1:0][word_width_lp-1:0] resp_rdata;

  logic [num_masters_lp-1:0] mem_v;
  logic [num_masters_lp-1:0] mem_ready;
  logic [num_masters_lp-1:0] mem_we;
  logic [num_masters_lp-1:0][block_addr_width_lp-1:0] mem_addr;
  logic [num_masters_lp-1:0][block_width_lp-1:0] mem_wdata;
  logic [num_masters_lp-1:0] mem_rdata_v;
  logic [num_masters_lp-1:0][block_width_lp-1:0] mem_rdata;

  assign finish_o = &done;

  cfg_regs regs (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.cfg_we_i(cfg_we_i)
    ,.cfg_addr_i(cfg_addr_i)
    ,.cfg_wdata_i(cfg_wdata_i)
    ,.cfg_rdata_o(cfg_rdata_o)
    ,.base_o(base)
    ,.count_o(count)
    ,.key_o(key)
    ,.start_o(start)
    ,.done_i(done)
    ,.mismatch_i(mismatch)
  );

  for (genvar m = 0; m < num_masters_lp; m++) begin : node
    test_master master (
      .clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.start_i(start[m])
      ,.base_i(base[m])
      ,.count_i(count[m])
      ,.key_i(key[m])
      ,.req_v_o(req_v[m])
      ,.req_ready_i(req_ready[m])
      ,.req_op_o(req_op[m])
      ,.req_addr_o(req_addr[m])
      ,.req_wdata_o(req_wdata[m])
      ,.resp_v_i(resp_v[m])
      ,.resp_rdata_i(resp_rdata[m])
      ,.done_o(done[m])
      ,.mismatch_o(mismatch[m])
    );

    block_cache cache (
      .clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.req_v_i(req_v[m])
      ,.req_ready_o(req_ready[m])
      ,.req_op_i(req_op[m])
      ,.req_addr_i(req_addr[m])
      ,.req_wdata_i(req_wdata[m])
      ,.resp_v_o(resp_v[m])
      ,.resp_rdata_o(resp_rdata[m])
      ,.mem_v_o(mem_v[m])
      ,.mem_ready_i(mem_ready[m])
      ,.mem_we_o(mem_we[m])
      ,.mem_addr_o(mem_addr[m])
      ,.mem_wdata_o(mem_wdata[m])
      ,.mem_rdata_v_i(mem_rdata_v[m])
      ,.mem_rdata_i(mem_rdata[m])
    );
  end

  cache_to_app adapter (
    .clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.mem_v_i(mem_v)
    ,.mem_ready_o(mem_ready)
    ,.mem_we_i(mem_we)
    ,.mem_addr_i(mem_addr)
    ,.mem_wdata_i(mem_wdata)
    ,.mem_rdata_v_o(mem_rdata_v)
    ,.mem_rdata_o(mem_rdata)
    ,.app_en_o(app_en_o)
    ,.app_rdy_i(app_rdy_i)
    ,.app_cmd_o(app_cmd_o)
    ,.app_addr_o(app_addr_o)
    ,.app_wdf_wren_o(app_wdf_wren_o)
    ,.app_wdf_rdy_i(app_wdf_rdy_i)
    ,.app_wdf_data_o(app_wdf_data_o)
    ,.app_rd_data_valid_i(app_rd_data_valid_i)
    ,.app_rd_data_i(app_rd_data_i)
    ,.init_calib_complete_i(init_calib_complete_i)
  );

endmodule

`default_nettype wire

//--- rtl/cache_to_app.sv
`timescale 1ns/1ps
`default_nettype none

module cache_to_app
  import cache_pkg::*;
  import dram_app_pkg::*;
(
  input logic clk_i
  ,input logic reset_i

  ,input logic [num_masters_lp-1:0] mem_v_i
  ,output logic [num_masters_lp-1:0] mem_ready_o
  ,input logic [num_masters_lp-1:0] mem_we_i
  ,input logic [num_masters_lp-1:0][block_addr_width_lp-1:0] mem_addr_i
  ,input logic [num_masters_lp-1:0][block_width_lp-1:0] mem_wdata_i
  ,output logic [num_masters_lp-1:0] mem_rdata_v_o
  ,output logic [num_masters_lp-1:0][block_width_lp-1:0] mem_rdata_o

  ,output logic app_en_o
  ,input logic app_rdy_i
  ,output app_cmd_e app_cmd_o
  ,output logic [app_addr_width_lp-1:0] app_addr_o
  ,output logic app_wdf_wren_o
  ,input logic app_wdf_rdy_i
  ,output logic [app_data_width_lp-1:0] app_wdf_data_o
  ,input logic app_rd_data_valid_i
  ,input logic [app_data_width_lp-1:0] app_rd_data_i
  ,input logic init_calib_complete_i
);

  // two caches, so the grant and priority pointer are one bit.
  logic rr_r;
  logic busy_r;
  logic grant_r;
  logic we_r;
  logic cmd_done_r;
  logic wdf_done_r;
  logic [app_addr_width_lp-1:0] addr_r;
  logic [app_data_width_lp-1:0] wdata_r;

  logic gnt_v;
  logic gnt_idx;
  logic cmd_fire;
  logic wdf_fire;
  logic wr_end;
  logic rd_end;

  always_comb begin
    gnt_v = 1'b0;
    gnt_idx = rr_r;
    if (!busy_r && init_calib_complete_i) begin
      if (mem_v_i[rr_r]) begin
        gnt_v = 1'b1;
      end else if (mem_v_i[~rr_r]) begin
        gnt_v = 1'b1;
        gnt_idx = ~rr_r;
      end
    end
  end

  assign app_en_o = busy_r && !cmd_done_r;
  assign app_cmd_o = we_r ? APP_CMD_WRITE : APP_CMD_READ;
  assign app_addr_o = addr_r;
  assign app_wdf_wren_o = busy_r && we_r && !wdf_done_r;
  assign app_wdf_data_o = wdata_r;

  assign cmd_fire = app_en_o && app_rdy_i;
  assign wdf_fire = app_wdf_wren_o && app_wdf_rdy_i;

  // a write needs both channels, in either order.
  assign wr_end = busy_r && we_r && (cmd_done_r || cmd_fire) && (wdf_done_r || wdf_fire);
  assign rd_end = busy_r && !we_r && (cmd_done_r || cmd_fire) && app_rd_data_valid_i;

  for (genvar m = 0; m < num_masters_lp; m++) begin : route
    assign mem_ready_o[m] = gnt_v && (gnt_idx == 1'(m));
    assign mem_rdata_v_o[m] = rd_end && (grant_r == 1'(m));
    assign mem_rdata_o[m] = app_rd_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_r <= 1'b0;
      busy_r <= 1'b0;
      cmd_done_r <= 1'b0;
      wdf_done_r <= 1'b0;
    end else if (gnt_v) begin
      busy_r <= 1'b1;
      cmd_done_r <= 1'b0;
      wdf_done_r <= !mem_we_i[gnt_idx];
      rr_r <= ~gnt_idx;
    end else if (busy_r) begin
      if (cmd_fire) begin
        cmd_done_r <= 1'b1;
      end
      if (wdf_fire) begin
        wdf_done_r <= 1'b1;
      end
      if (wr_end || rd_end) begin
        busy_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_v) begin
      grant_r <= gnt_idx;
      we_r <= mem_we_i[gnt_idx];
      addr_r <= app_addr_width_lp'(mem_addr_i[gnt_idx]);
      wdata_r <= mem_wdata_i[gnt_idx];
    end
  end

  cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    app_en_o && !app_rdy_i |=> $stable(app_cmd_o) && $stable(app_addr_o));

endmodule

`default_nettype wire

//--- rtl/block_cache.sv
`timescale 1ns/1ps
`default_nettype none

module block_cache
  import cache_pkg::*;
(
  input logic clk_i
  ,input logic reset_i

  ,input logic req_v_i
  ,output logic req_ready_o
  ,input cache_op_e req_op_i
  ,input logic [addr_width_lp-1:0] req_addr_i
  ,input logic [word_width_lp-1:0] req_wdata_i
  ,output logic resp_v_o
  ,output logic [word_width_lp-1:0] resp_rdata_o

  ,output logic mem_v_o
  ,input logic mem_ready_i
  ,output logic mem_we_o
  ,output logic [block_addr_width_lp-1:0] mem_addr_o
  ,output logic [block_width_lp-1:0] mem_wdata_o
  ,input logic mem_rdata_v_i
  ,input logic [block_width_lp-1:0] mem_rdata_i
);

  cache_state_e state_r;

  logic [tag_width_lp-1:0] tag_r [sets_lp];
  logic [block_width_lp-1:0] data_r [sets_lp];
  logic [sets_lp-1:0] valid_r;
  logic [sets_lp-1:0] dirty_r;

  cache_op_e op_r;
  logic [addr_width_lp-1:0] addr_r;
  logic [word_width_lp-1:0] wdata_r;
  logic fill_sent_r;

  logic [index_width_lp-1:0] idx;
  logic [word_offset_width_lp-1:0] woff;
  logic [tag_width_lp-1:0] tag;
  logic [block_width_lp-1:0] line;
  logic hit;

  function automatic logic [block_width_lp-1:0] merge_word(
    input logic [block_width_lp-1:0] blk
    ,input logic [word_offset_width_lp-1:0] off
    ,input logic [word_width_lp-1:0] word
  );
    logic [block_width_lp-1:0] res;
    res = blk;
    res[off*word_width_lp +: word_width_lp] = word;
    return res;
  endfunction

  assign idx = addr_r[offset_width_lp +: index_width_lp];
  assign woff = addr_r[byte_offset_width_lp +: word_offset_width_lp];
  assign tag = addr_r[addr_width_lp-1 -: tag_width_lp];
  assign line = data_r[idx];
  assign hit = valid_r[idx] && (tag_r[idx] == tag);

  assign req_ready_o = (state_r == IDLE);

  // hits answer from lookup, misses from resp after the fill is written.
  assign resp_v_o = ((state_r == LOOKUP) && hit) || (state_r == RESP);
  assign resp_rdata_o = line[woff*word_width_lp +: word_width_lp];

  assign mem_v_o = (state_r == EVICT) || ((state_r == FILL) && !fill_sent_r);
  assign mem_we_o = (state_r == EVICT);
  assign mem_addr_o = mem_we_o ? {tag_r[idx], idx} : addr_r[addr_width_lp-1:offset_width_lp];
  assign mem_wdata_o = line;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      valid_r <= '0;
      dirty_r <= '0;
      fill_sent_r <= 1'b0;
    end else begin
      case (state_r)
        IDLE: begin
          if (req_v_i) begin
            state_r <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (hit) begin
            state_r <= IDLE;
            if (op_r == OP_STORE) begin
              dirty_r[idx] <= 1'b1;
            end
          end else if (valid_r[idx] && dirty_r[idx]) begin
            state_r <= EVICT;
          end else begin
            state_r <= FILL;
          end
        end
        EVICT: begin
          // victim goes out before the fill is requested.
          if (mem_ready_i) begin
            dirty_r[idx] <= 1'b0;
            state_r <= FILL;
          end
        end
        FILL: begin
          if (mem_v_o && mem_ready_i) begin
            fill_sent_r <= 1'b1;
          end
          if (mem_rdata_v_i) begin
            fill_sent_r <= 1'b0;
            valid_r[idx] <= 1'b1;
            dirty_r[idx] <= (op_r == OP_STORE);
            state_r <= RESP;
          end
        end
        RESP: state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i && req_ready_o) begin
      op_r <= req_op_i;
      addr_r <= req_addr_i;
      wdata_r <= req_wdata_i;
    end
    if ((state_r == LOOKUP) && hit && (op_r == OP_STORE)) begin
      data_r[idx] <= merge_word(line, woff, wdata_r);
    end
    // store miss merges into the incoming block.
    if ((state_r == FILL) && mem_rdata_v_i) begin
      tag_r[idx] <= tag;
      data_r[idx] <= (op_r == OP_STORE) ? merge_word(mem_rdata_i, woff, wdata_r) : mem_rdata_i;
    end
  end

  no_resp_after_reset: assert property (@(posedge clk_i) reset_i |=> !resp_v_o);

  mem_v_held: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_v_o && !mem_ready_i |=> mem_v_o);

endmodule

`default_nettype wire

//--- rtl/test_master.sv
`timescale 1ns/1ps
`default_nettype none

module test_master
  import cache_pkg::*;
(
  input logic clk_i
  ,input logic reset_i

  ,input logic start_i
  ,input logic [addr_width_lp-1:0] base_i
  ,input logic [count_width_lp-1:0] count_i
  ,input logic [word_width_lp-1:0] key_i

  ,output logic req_v_o
  ,input logic req_ready_i
  ,output cache_op_e req_op_o
  ,output logic [addr_width_lp-1:0] req_addr_o
  ,output logic [word_width_lp-1:0] req_wdata_o
  ,input logic resp_v_i
  ,input logic [word_width_lp-1:0] resp_rdata_i

  ,output logic done_o
  ,output logic [count_width_lp-1:0] mismatch_o
);

  typedef enum logic [1:0] {M_IDLE, M_STORE, M_LOAD, M_DONE} master_state_e;

  master_state_e state_r;
  logic pending_r;
  logic [count_width_lp-1:0] idx_r;
  logic last;

  // word k lives at base + 4k and holds key ^ address.
  assign req_addr_o = base_i + addr_width_lp'({idx_r, 2'b00});
  assign req_wdata_o = key_i ^ req_addr_o;
  assign req_op_o = (state_r == M_LOAD) ? OP_LOAD : OP_STORE;

  // one request in flight.
  assign req_v_o = ((state_r == M_STORE) || (state_r == M_LOAD)) && !pending_r;

  assign last = (idx_r == count_i - 1'b1);
  assign done_o = (state_r == M_DONE);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= M_IDLE;
      pending_r <= 1'b0;
      idx_r <= '0;
      mismatch_o <= '0;
    end else begin
      if (req_v_o && req_ready_i) begin
        pending_r <= 1'b1;
      end
      if (resp_v_i) begin
        pending_r <= 1'b0;
        idx_r <= last ? '0 : idx_r + 1'b1;
      end

      case (state_r)
        M_IDLE, M_DONE: begin
          if (start_i) begin
            idx_r <= '0;
            mismatch_o <= '0;
            state_r <= (count_i == '0) ? M_DONE : M_STORE;
          end
        end
        M_STORE: begin
          if (resp_v_i && last) begin
            state_r <= M_LOAD;
          end
        end
        M_LOAD: begin
          if (resp_v_i) begin
            // the in-flight index still selects the expected word.
            if (resp_rdata_i != req_wdata_o) begin
              mismatch_o <= mismatch_o + 1'b1;
            end
            if (last) begin
              state_r <= M_DONE;
            end
          end
        end
        default: state_r <= M_IDLE;
      endcase
    end
  end

  resp_needs_request: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i |-> pending_r);

endmodule

`default_nettype wire

//--- rtl/cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
  import cache_pkg::*;
(
  input logic clk_i
  ,input logic reset_i

  ,input logic cfg_we_i
  ,input logic [cfg_addr_width_lp-1:0] cfg_addr_i
  ,input logic [word_width_lp-1:0] cfg_wdata_i
  ,output logic [word_width_lp-1:0] cfg_rdata_o

  ,output logic [num_masters_lp-1:0][addr_width_lp-1:0] base_o
  ,output logic [num_masters_lp-1:0][count_width_lp-1:0] count_o
  ,output logic [num_masters_lp-1:0][word_width_lp-1:0] key_o
  ,output logic [num_masters_lp-1:0] start_o
  ,input logic [num_masters_lp-1:0] done_i
  ,input logic [num_masters_lp-1:0][count_width_lp-1:0] mismatch_i
);

  logic [count_width_lp-1:0] mismatch_sum;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      base_o <= '0;
      count_o <= '0;
      key_o <= '0;
      start_o <= '0;
    end else begin
      start_o <= '0;
      if (cfg_we_i) begin
        for (int m = 0; m < num_masters_lp; m++) begin
          if (cfg_addr_i == cfg_addr_width_lp'(3*m)) begin
            base_o[m] <= cfg_wdata_i;
          end
          if (cfg_addr_i == cfg_addr_width_lp'(3*m+1)) begin
            count_o[m] <= cfg_wdata_i[count_width_lp-1:0];
          end
          if (cfg_addr_i == cfg_addr_width_lp'(3*m+2)) begin
            key_o[m] <= cfg_wdata_i;
          end
        end
        // one cycle start pulse per selected master.
        if (cfg_addr_i == cfg_addr_width_lp'(cfg_start_addr_lp)) begin
          start_o <= cfg_wdata_i[num_masters_lp-1:0];
        end
      end
    end
  end

  always_comb begin
    mismatch_sum = '0;
    for (int m = 0; m < num_masters_lp; m++) begin
      mismatch_sum = mismatch_sum + mismatch_i[m];
    end
  end

  always_comb begin
    cfg_rdata_o = '0;
    for (int m = 0; m < num_masters_lp; m++) begin
      if (cfg_addr_i == cfg_addr_width_lp'(3*m)) begin
        cfg_rdata_o = base_o[m];
      end
      if (cfg_addr_i == cfg_addr_width_lp'(3*m+1)) begin
        cfg_rdata_o = word_width_lp'(count_o[m]);
      end
      if (cfg_addr_i == cfg_addr_width_lp'(3*m+2)) begin
        cfg_rdata_o = key_o[m];
      end
    end
    // status word.
    if (cfg_addr_i == cfg_addr_width_lp'(cfg_status_addr_lp)) begin
      cfg_rdata_o = {mismatch_sum, {(word_width_lp-count_width_lp-num_masters_lp){1'b0}}, done_i};
    end
  end

  cfg_write_in_map: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_we_i |-> cfg_addr_i <= cfg_addr_width_lp'(cfg_status_addr_lp));

endmodule

`default_nettype wire

//--- rtl/dram_app_pkg.sv
`default_nettype none

package dram_app_pkg;

  // one application address per 128-bit block.
  localparam int app_addr_width_lp = 28;
  localparam int app_data_width_lp = 128;

  // controller command codes, only write and read are issued.
  typedef enum logic [2:0] {
    APP_CMD_WRITE = 3'd0,
    APP_CMD_READ  = 3'd1
  } app_cmd_e;

endpackage

`default_nettype wire

//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // two master and cache pairs share one DRAM port.
  localparam int num_masters_lp = 2;

  localparam int word_width_lp = 32;
  localparam int addr_width_lp = 32;

  // direct mapped, 8 sets of 4 words.
  localparam int block_words_lp = 4;
  localparam int sets_lp = 8;
  localparam int block_width_lp = word_width_lp * block_words_lp;

  // byte address is tag, index, word offset, byte offset.
  localparam int byte_offset_width_lp = 2;
  localparam int word_offset_width_lp = 2;
  localparam int offset_width_lp = byte_offset_width_lp + word_offset_width_lp;
  localparam int index_width_lp = 3;
  localparam int tag_width_lp = addr_width_lp - offset_width_lp - index_width_lp;
  localparam int block_addr_width_lp = addr_width_lp - offset_width_lp;

  localparam int count_width_lp = 16;

  // configuration register map.
  localparam int cfg_addr_width_lp = 4;
  localparam int cfg_start_addr_lp = 6;
  localparam int cfg_status_addr_lp = 7;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } cache_op_e;

  typedef enum logic [2:0] {IDLE, LOOKUP, EVICT, FILL, RESP} cache_state_e;

endpackage

`default_nettype wire
